// ==== rtl/fpnc_pkg.sv ====
package fpnc_pkg;

  // ------------------------------------------------------------------------
  // FP32 field sizes
  // ------------------------------------------------------------------------
  localparam int unsigned FP_WIDTH = 32;
  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned MAN_BITS = 23;

  // One operand or result word
  typedef logic [FP_WIDTH-1:0] fp32_t;

  // ------------------------------------------------------------------------
  // Operation encoding
  // ------------------------------------------------------------------------
  // Rounding-mode field, reused as sub-operation select
  typedef logic [2:0] rnd_mode_t;

  localparam rnd_mode_t RNE = 3'd0; // SGNJ / MIN / LE
  localparam rnd_mode_t RTZ = 3'd1; // SGNJN / MAX / LT
  localparam rnd_mode_t RDN = 3'd2; // SGNJX / EQ
  localparam rnd_mode_t RUP = 3'd3; // Passthrough in sign injection

  // Operation group
  typedef logic [1:0] op_t;

  localparam op_t OP_SGNJ   = 2'd0;
  localparam op_t OP_MINMAX = 2'd1;
  localparam op_t OP_CMP    = 2'd2;

  // ------------------------------------------------------------------------
  // Exception status
  // ------------------------------------------------------------------------
  // Flags NV DZ OF UF NX, MSB first
  typedef logic [4:0] status_t;

  localparam int unsigned STATUS_NV = 4; // Invalid operation

  // Canonical quiet NaN, positive sign and top mantissa bit set
  localparam fp32_t CANON_NAN = 32'h7fc0_0000;

endpackage

// ==== rtl/fp_classifier.sv ====
`timescale 1ns/1ps

module fp_classifier (
  input  fpnc_pkg::fp32_t operand_a_i,
  input  fpnc_pkg::fp32_t operand_b_i,
  output logic [1:0]      is_zero_o, // [0] operand a, [1] operand b
  output logic [1:0]      is_inf_o,
  output logic [1:0]      is_nan_o,
  output logic [1:0]      is_snan_o
);

  // Both operands side by side, index 0 is a
  fpnc_pkg::fp32_t [1:0] operands;

  assign operands = {operand_b_i, operand_a_i};

  for (genvar i = 0; i < 2; i++) begin : gen_class
    logic [fpnc_pkg::EXP_BITS-1:0] exponent;
    logic [fpnc_pkg::MAN_BITS-1:0] mantissa;
    logic                          exp_ones;
    logic                          exp_zero;
    logic                          man_zero;

    // Field split, sign bit is ignored here
    assign exponent = operands[i][fpnc_pkg::FP_WIDTH-2 -: fpnc_pkg::EXP_BITS];
    assign mantissa = operands[i][fpnc_pkg::MAN_BITS-1:0];

    assign exp_ones = &exponent;
    assign exp_zero = ~|exponent;
    assign man_zero = ~|mantissa;

    assign is_zero_o[i] = exp_zero & man_zero;       // +0 or -0
    assign is_inf_o[i]  = exp_ones & man_zero;
    assign is_nan_o[i]  = exp_ones & ~man_zero;
    // Quiet bit clear means signalling
    assign is_snan_o[i] = is_nan_o[i] & ~mantissa[fpnc_pkg::MAN_BITS-1];
  end

endmodule

// ==== rtl/fpnc_pipe.sv ====
`timescale 1ns/1ps

module fpnc_pipe #(
  parameter int unsigned NumPipeRegs = 1,
  parameter int unsigned DataWidth   = 32,
  parameter int unsigned TagWidth    = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Upstream side
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic [DataWidth-1:0] data_i,
  input  logic [TagWidth-1:0]  tag_i,
  // Downstream side
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [DataWidth-1:0] data_o,
  output logic [TagWidth-1:0]  tag_o,
  // Any stage occupied
  output logic                 busy_o
);

  // Index 0 is the input and index NumPipeRegs the last register
  logic [NumPipeRegs:0] stage_valid;
  logic [NumPipeRegs:0] stage_ready;
  logic [DataWidth-1:0] stage_data [0:NumPipeRegs];
  logic [TagWidth-1:0]  stage_tag  [0:NumPipeRegs];

  assign stage_valid[0] = in_valid_i;
  assign stage_data[0]  = data_i;
  assign stage_tag[0]   = tag_i;
  assign in_ready_o     = stage_ready[0];

  // ------------------------------------------------------------------------
  // Register stages
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic                 valid_q;
    logic [DataWidth-1:0] data_q;
    logic [TagWidth-1:0]  tag_q;

    // Stage can take a new item if the next one moves or this one is empty
    assign stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        valid_q <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q <= stage_valid[i]; // Bubble moves in when upstream idle
      end
    end

    // Payload registers
    always_ff @(posedge clk_i) begin
      if (stage_ready[i]) begin
        data_q <= stage_data[i];
        tag_q  <= stage_tag[i];
      end
    end

    assign stage_valid[i+1] = valid_q;
    assign stage_data[i+1]  = data_q;
    assign stage_tag[i+1]   = tag_q;
  end

  // Last stage faces the consumer
  assign stage_ready[NumPipeRegs] = out_ready_i;
  assign out_valid_o              = stage_valid[NumPipeRegs];
  assign data_o                   = stage_data[NumPipeRegs];
  assign tag_o                    = stage_tag[NumPipeRegs];

  if (NumPipeRegs == 0) begin : gen_no_busy
    assign busy_o = 1'b0; // Pure wires with nothing held
  end else begin : gen_busy
    assign busy_o = |stage_valid[NumPipeRegs:1];
  end

endmodule

// ==== rtl/fp_noncomp.sv ====
`timescale 1ns/1ps

module fp_noncomp #(
  parameter int unsigned NumPipeRegs = 0,
  parameter int unsigned PipeAfter   = 0,
  parameter int unsigned TagWidth    = 8
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  fpnc_pkg::fp32_t         operand_a_i,
  input  fpnc_pkg::fp32_t         operand_b_i,
  input  fpnc_pkg::op_t           op_i,
  input  fpnc_pkg::rnd_mode_t     rnd_mode_i,
  input  logic                    op_mod_i,
  input  logic [TagWidth-1:0]     tag_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  output fpnc_pkg::fp32_t         result_o,
  output fpnc_pkg::status_t       status_o,
  output logic                    extension_bit_o,
  output logic [TagWidth-1:0]     tag_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output logic                    busy_o
);

  localparam int unsigned FpW = fpnc_pkg::FP_WIDTH;
  // Packed word widths for the two pipeline placements
  localparam int unsigned OpWidth  = 2*FpW + $bits(fpnc_pkg::op_t)
                                     + $bits(fpnc_pkg::rnd_mode_t) + 1;
  localparam int unsigned ResWidth = FpW + $bits(fpnc_pkg::status_t) + 1;

  // Operation fields as seen by the datapath
  fpnc_pkg::fp32_t     operand_a_q;
  fpnc_pkg::fp32_t     operand_b_q;
  fpnc_pkg::op_t       op_q;
  fpnc_pkg::rnd_mode_t rnd_mode_q;
  logic                op_mod_q;

  // Datapath results
  fpnc_pkg::fp32_t     result_d;
  fpnc_pkg::status_t   status_d;
  logic                extension_bit_d;

  // ------------------------------------------------------------------------
  // Pipeline placement
  // ------------------------------------------------------------------------
  if (PipeAfter == 0) begin : gen_pipe_before
    logic [OpWidth-1:0] op_word;

    fpnc_pipe #(
      .NumPipeRegs ( NumPipeRegs ),
      .DataWidth   ( OpWidth     ),
      .TagWidth    ( TagWidth    )
    ) u_pipe (
      .clk_i       ( clk_i       ),
      .rst_i       ( rst_i       ),
      .in_valid_i  ( in_valid_i  ),
      .in_ready_o  ( in_ready_o  ),
      .data_i      ( {operand_a_i, operand_b_i, op_i, rnd_mode_i, op_mod_i} ),
      .tag_i       ( tag_i       ),
      .out_valid_o ( out_valid_o ),
      .out_ready_i ( out_ready_i ),
      .data_o      ( op_word     ),
      .tag_o       ( tag_o       ),
      .busy_o      ( busy_o      )
    );

    assign {operand_a_q, operand_b_q, op_q, rnd_mode_q, op_mod_q} = op_word;

    // Results leave combinationally
    assign result_o        = result_d;
    assign status_o        = status_d;
    assign extension_bit_o = extension_bit_d;
  end else begin : gen_pipe_after
    logic [ResWidth-1:0] res_word;

    assign operand_a_q = operand_a_i;
    assign operand_b_q = operand_b_i;
    assign op_q        = op_i;
    assign rnd_mode_q  = rnd_mode_i;
    assign op_mod_q    = op_mod_i;

    fpnc_pipe #(
      .NumPipeRegs ( NumPipeRegs ),
      .DataWidth   ( ResWidth    ),
      .TagWidth    ( TagWidth    )
    ) u_pipe (
      .clk_i       ( clk_i       ),
      .rst_i       ( rst_i       ),
      .in_valid_i  ( in_valid_i  ),
      .in_ready_o  ( in_ready_o  ),
      .data_i      ( {result_d, status_d, extension_bit_d} ),
      .tag_i       ( tag_i       ),
      .out_valid_o ( out_valid_o ),
      .out_ready_i ( out_ready_i ),
      .data_o      ( res_word    ),
      .tag_o       ( tag_o       ),
      .busy_o      ( busy_o      )
    );

    assign {result_o, status_o, extension_bit_o} = res_word;
  end

  // ------------------------------------------------------------------------
  // Classification and shared compare
  // ------------------------------------------------------------------------
  logic [1:0] is_zero;
  logic [1:0] is_nan;
  logic [1:0] is_snan;

  fp_classifier u_class (
    .operand_a_i ( operand_a_q ),
    .operand_b_i ( operand_b_q ),
    .is_zero_o   ( is_zero     ),
    .is_inf_o    (             ), // Raw compare already orders infinities
    .is_nan_o    ( is_nan      ),
    .is_snan_o   ( is_snan     )
  );

  logic sign_a;
  logic sign_b;
  logic any_nan;
  logic any_snan;
  logic operands_equal;
  logic a_smaller;

  assign sign_a   = operand_a_q[FpW-1];
  assign sign_b   = operand_b_q[FpW-1];
  assign any_nan  = |is_nan;
  assign any_snan = |is_snan;

  // +0 and -0 count as equal
  assign operands_equal = (operand_a_q == operand_b_q) | (&is_zero);
  // Unsigned compare of the raw words, flipped once a sign is set
  assign a_smaller      = (operand_a_q < operand_b_q) ^ (sign_a | sign_b);

  // Sign injection, sub-op in rnd_mode
  fpnc_pkg::fp32_t sgnj_result;

  always_comb begin
    sgnj_result = operand_a_q; // Magnitude always from a
    case (rnd_mode_q)
      fpnc_pkg::RNE: sgnj_result[FpW-1] = sign_b;          // SGNJ
      fpnc_pkg::RTZ: sgnj_result[FpW-1] = ~sign_b;         // SGNJN
      fpnc_pkg::RDN: sgnj_result[FpW-1] = sign_a ^ sign_b; // SGNJX
      fpnc_pkg::RUP: sgnj_result        = operand_a_q;     // Passthrough
      default:       sgnj_result        = 'x;
    endcase
  end

  // Min/max with quiet NaN handling
  fpnc_pkg::fp32_t minmax_result;

  always_comb begin
    if (is_nan[0] && is_nan[1]) begin
      minmax_result = fpnc_pkg::CANON_NAN;
    end else if (is_nan[0]) begin
      minmax_result = operand_b_q; // Non-NaN side wins
    end else if (is_nan[1]) begin
      minmax_result = operand_a_q;
    end else begin
      case (rnd_mode_q)
        fpnc_pkg::RNE: minmax_result = a_smaller ? operand_a_q : operand_b_q; // MIN
        fpnc_pkg::RTZ: minmax_result = a_smaller ? operand_b_q : operand_a_q; // MAX
        default:       minmax_result = 'x;
      endcase
    end
  end

  // Compares, boolean in bit 0
  fpnc_pkg::fp32_t cmp_result;
  logic            cmp_nv;

  always_comb begin
    cmp_result = '0;
    cmp_nv     = 1'b0;
    if (any_snan) begin
      cmp_nv = 1'b1; // Always invalid, result false
    end else begin
      case (rnd_mode_q)
        fpnc_pkg::RNE: begin // LE, signalling
          if (any_nan) cmp_nv = 1'b1;
          else cmp_result[0] = (a_smaller | operands_equal) ^ op_mod_q;
        end
        fpnc_pkg::RTZ: begin // LT, signalling
          if (any_nan) cmp_nv = 1'b1;
          else cmp_result[0] = (a_smaller & ~operands_equal) ^ op_mod_q;
        end
        fpnc_pkg::RDN: begin // EQ, quiet
          if (any_nan) cmp_result[0] = op_mod_q; // Unordered never equal
          else cmp_result[0] = operands_equal ^ op_mod_q;
        end
        default: begin
          cmp_result = 'x;
          cmp_nv     = 1'bx;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // Result selection
  // ------------------------------------------------------------------------
  always_comb begin
    status_d = '0;
    case (op_q)
      fpnc_pkg::OP_SGNJ: begin
        result_d        = sgnj_result;                          // Never flags
        extension_bit_d = op_mod_q ? sgnj_result[FpW-1] : 1'b1; // Int sign-ext or NaN-box
      end
      fpnc_pkg::OP_MINMAX: begin
        result_d                     = minmax_result;
        status_d[fpnc_pkg::STATUS_NV] = any_snan;
        extension_bit_d              = 1'b1; // Float result
      end
      fpnc_pkg::OP_CMP: begin
        result_d                     = cmp_result;
        status_d[fpnc_pkg::STATUS_NV] = cmp_nv;
        extension_bit_d              = 1'b0; // Integer boolean
      end
      default: begin
        result_d        = 'x;
        status_d        = 'x;
        extension_bit_d = 1'bx;
      end
    endcase
  end

endmodule

// ==== rtl/fpnc_top.sv ====
`timescale 1ns/1ps

module fpnc_top #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned PipeAfter   = 0, // Registers ahead of the datapath
  parameter int unsigned TagWidth    = 8
) (
  input  logic                clk_i,
  input  logic                rst_i,
  // Input handshake and operation
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  fpnc_pkg::fp32_t     operands_a_i,
  input  fpnc_pkg::fp32_t     operand_b_i,
  input  fpnc_pkg::op_t       op_i,
  input  fpnc_pkg::rnd_mode_t rnd_mode_i,
  input  logic                op_mod_i,
  input  logic [TagWidth-1:0] tag_i,
  // Output handshake and result
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output fpnc_pkg::fp32_t     result_o,
  output fpnc_pkg::status_t   status_o,
  output logic                extension_bit_o,
  output logic [TagWidth-1:0] tag_o,
  output logic                busy_o
);

  fp_noncomp #(
    .NumPipeRegs ( NumPipeRegs ),
    .PipeAfter   ( PipeAfter   ),
    .TagWidth    ( TagWidth    )
  ) u_noncomp (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .operand_a_i     ( operands_a_i    ),
    .operand_b_i     ( operand_b_i     ),
    .op_i            ( op_i            ),
    .rnd_mode_i      ( rnd_mode_i      ),
    .op_mod_i        ( op_mod_i        ),
    .tag_i           ( tag_i           ),
    .in_valid_i      ( in_valid_i      ),
    .in_ready_o      ( in_ready_o      ),
    .result_o        ( result_o        ),
    .status_o        ( status_o        ),
    .extension_bit_o ( extension_bit_o ),
    .tag_o           ( tag_o           ),
    .out_valid_o     ( out_valid_o     ),
    .out_ready_i     ( out_ready_i     ),
    .busy_o          ( busy_o          )
  );

endmodule

// ==== bench/fpnc_checker.sv ====
`timescale 1ns/1ps

module fpnc_checker #(
  parameter int unsigned TagWidth = 8
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                out_valid_i,
  input  logic                out_ready_i,
  input  fpnc_pkg::fp32_t     result_i,
  input  fpnc_pkg::status_t   status_i,
  input  logic                extension_bit_i,
  input  logic [TagWidth-1:0] tag_i,
  output int                  error_count_o,
  output int                  recv_count_o
);

  int errors   = 0;
  int received = 0; // Also the index of the next expected vector

  assign error_count_o = errors;
  assign recv_count_o  = received;

  // Expected values live in the testbench vector table
  task automatic compare_item(input int idx);
    logic [TagWidth-1:0] exp_tag;
    exp_tag = TagWidth'(idx); // Tag is the vector index
    if (result_i !== tb_fpnc_top.exp_result[idx]) begin
      $display("[FAIL] result_o tag %h: got %h, expected %h",
               exp_tag, result_i, tb_fpnc_top.exp_result[idx]);
      errors++;
    end
    if (status_i !== tb_fpnc_top.exp_status[idx]) begin
      $display("[FAIL] status_o tag %h: got %h, expected %h",
               exp_tag, status_i, tb_fpnc_top.exp_status[idx]);
      errors++;
    end
    if (extension_bit_i !== tb_fpnc_top.exp_ext[idx]) begin
      $display("[FAIL] extension_bit_o tag %h: got %h, expected %h",
               exp_tag, extension_bit_i, tb_fpnc_top.exp_ext[idx]);
      errors++;
    end
    if (tag_i !== exp_tag) begin
      $display("[FAIL] tag_o: got %h, expected %h", tag_i, exp_tag); // Order or loss
      errors++;
    end
  endtask

  // Output transfer, pre-edge values
  always @(posedge clk_i) begin
    if (!rst_i && out_valid_i && out_ready_i) begin
      if (received >= tb_fpnc_top.num_vec) begin
        $display("Extra output item with tag %h after the last vector", tag_i);
        errors++;
      end else begin
        compare_item(received);
      end
      received++;
    end
  end

endmodule

// ==== bench/fpnc_sva.sv ====
`timescale 1ns/1ps

module fpnc_sva #(
  parameter int unsigned TagWidth = 8
) (
  input logic                clk_i,
  input logic                rst_i,
  input logic                in_ready_i,
  input logic                out_valid_i,
  input logic                out_ready_i,
  input fpnc_pkg::fp32_t     result_i,
  input fpnc_pkg::status_t   status_i,
  input logic                extension_bit_i,
  input logic [TagWidth-1:0] tag_i,
  input logic                busy_i
);

  // Failure tallies per assertion
  int stall_fails = 0;
  int reset_fails = 0;
  int ready_fails = 0;
  int fail_count;

  assign fail_count = stall_fails + reset_fails + ready_fails;

  // Stalled output keeps valid and payload
  a_stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(result_i) && $stable(status_i)
      && $stable(extension_bit_i) && $stable(tag_i))
    else begin
      $error("Output dropped or changed while out_ready_i was low");
      stall_fails++;
    end

  // Pipeline empty right after reset
  a_reset_idle: assert property (@(posedge clk_i) rst_i |=> !out_valid_i && !busy_i)
    else begin
      $error("out_valid_o or busy_o high in the cycle after reset");
      reset_fails++;
    end

  // Empty pipeline always accepts
  a_idle_ready: assert property (@(posedge clk_i) disable iff (rst_i) !busy_i |-> in_ready_i)
    else begin
      $error("in_ready_o low while busy_o is low");
      ready_fails++;
    end

endmodule

bind fpnc_top fpnc_sva #(.TagWidth(TagWidth)) u_sva (
  .clk_i           ( clk_i           ),
  .rst_i           ( rst_i           ),
  .in_ready_i      ( in_ready_o      ),
  .out_valid_i     ( out_valid_o     ),
  .out_ready_i     ( out_ready_i     ),
  .result_i        ( result_o        ),
  .status_i        ( status_o        ),
  .extension_bit_i ( extension_bit_o ),
  .tag_i           ( tag_o           ),
  .busy_i          ( busy_o          )
);

// ==== bench/tb_fpnc_top.sv ====
`timescale 1ns/1ps

module tb_fpnc_top;

  localparam int unsigned TagWidth = 8;
  localparam int unsigned Seed     = 32'hba86_af45;

  logic                clk_i;
  logic                rst_i;
  logic                in_valid_i;
  logic                in_ready_o;
  fpnc_pkg::fp32_t     operands_a_i;
  fpnc_pkg::fp32_t     operand_b_i;
  fpnc_pkg::op_t       op_i;
  fpnc_pkg::rnd_mode_t rnd_mode_i;
  logic                op_mod_i;
  logic [TagWidth-1:0] tag_i;
  logic                out_valid_o;
  logic                out_ready_i;
  fpnc_pkg::fp32_t     result_o;
  fpnc_pkg::status_t   status_o;
  logic                extension_bit_o;
  logic [TagWidth-1:0] tag_o;
  logic                busy_o;

  // Vector table, expected part read by the checker
  fpnc_pkg::fp32_t     vec_a [$];
  fpnc_pkg::fp32_t     vec_b [$];
  fpnc_pkg::op_t       vec_op [$];
  fpnc_pkg::rnd_mode_t vec_rnd [$];
  logic                vec_mod [$];
  fpnc_pkg::fp32_t     exp_result [$];
  fpnc_pkg::status_t   exp_status [$];
  logic                exp_ext [$];

  int num_vec   = 0;
  int limit     = 200; // Cycle budget, raised once vectors are loaded
  int tb_errors = 0;
  int error_count;
  int recv_count;

  fpnc_top u_dut (.*);

  fpnc_checker #(.TagWidth(TagWidth)) u_checker (
    .clk_i           ( clk_i           ),
    .rst_i           ( rst_i           ),
    .out_valid_i     ( out_valid_o     ),
    .out_ready_i     ( out_ready_i     ),
    .result_i        ( result_o        ),
    .status_i        ( status_o        ),
    .extension_bit_i ( extension_bit_o ),
    .tag_i           ( tag_o           ),
    .error_count_o   ( error_count     ),
    .recv_count_o    ( recv_count      )
  );

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  task automatic load_vectors();
    int                  fd;
    int                  n;
    string               line;
    fpnc_pkg::op_t       op_v;
    fpnc_pkg::rnd_mode_t rnd_v;
    logic                mod_v;
    fpnc_pkg::fp32_t     a_v;
    fpnc_pkg::fp32_t     b_v;
    fpnc_pkg::fp32_t     res_v;
    fpnc_pkg::status_t   st_v;
    logic                ext_v;
    fd = $fopen("bench/fpnc_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file bench/fpnc_stim.txt");
      tb_errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.substr(0, 1) == "//") continue; // Blank or comment
      n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                  op_v, rnd_v, mod_v, a_v, b_v, res_v, st_v, ext_v);
      if (n != 8) begin
        $display("Malformed stimulus line: %s", line);
        tb_errors++;
        continue;
      end
      vec_op.push_back(op_v);
      vec_rnd.push_back(rnd_v);
      vec_mod.push_back(mod_v);
      vec_a.push_back(a_v);
      vec_b.push_back(b_v);
      exp_result.push_back(res_v);
      exp_status.push_back(st_v);
      exp_ext.push_back(ext_v);
    end
    $fclose(fd);
    num_vec = vec_a.size();
  endtask

  // Called at a falling edge, returns at the falling edge after acceptance
  task automatic send_vector(input int idx);
    operands_a_i = vec_a[idx];
    operand_b_i  = vec_b[idx];
    op_i         = vec_op[idx];
    rnd_mode_i   = vec_rnd[idx];
    op_mod_i     = vec_mod[idx];
    tag_i        = TagWidth'(idx);
    in_valid_i   = 1'b1;
    @(posedge clk_i);
    while (!in_ready_o) @(posedge clk_i); // Held until accepted
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic finish_run(input logic timed_out);
    int total;
    total = tb_errors + error_count + int'(timed_out) + u_dut.u_sva.fail_count;
    $display("Errors: %0d, items received: %0d of %0d", total, recv_count, num_vec);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  // ------------------------------------------------------------------------
  // Clock, back-pressure, watchdog
  // ------------------------------------------------------------------------
  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i; // 20 ns period
  end

  initial begin : backpressure
    out_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      out_ready_i = rst_i || ($urandom_range(0, 3) != 0); // Stall about one cycle in four
    end
  end

  initial begin : watchdog
    int cycle_count;
    cycle_count = 0;
    while (cycle_count < limit) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, %0d of %0d items received",
             cycle_count, recv_count, num_vec);
    finish_run(1'b1);
  end

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------
  initial begin : main
    void'($urandom(Seed));
    rst_i        = 1'b1;
    in_valid_i   = 1'b0;
    operands_a_i = '0;
    operand_b_i  = '0;
    op_i         = '0;
    rnd_mode_i   = '0;
    op_mod_i     = 1'b0;
    tag_i        = '0;
    load_vectors();
    limit = num_vec * 16 + 200;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    for (int i = 0; i < num_vec; i++) begin
      repeat ($urandom_range(0, 2)) @(negedge clk_i); // Idle gap
      send_vector(i);
    end
    while (recv_count < num_vec) @(negedge clk_i);
    repeat (10) @(negedge clk_i); // Room for stray items
    if (recv_count != num_vec) begin
      $display("Item count wrong: received %0d, sent %0d", recv_count, num_vec);
      tb_errors++;
    end
    finish_run(1'b0);
  end

endmodule

// ==== bench/fpnc_stim.txt ====
// op rnd mod operand_a operand_b result status ext
// All fields hex, status bit 4 is NV, one vector per line
0 0 0 3f800000 c0000000 bf800000 00 1
0 1 0 3f800000 c0000000 3f800000 00 1
0 2 1 c0400000 c0000000 40400000 00 0
0 3 0 ff812345 00000000 ff812345 00 1
1 0 0 3f800000 40000000 3f800000 00 1
1 1 0 3f800000 40000000 40000000 00 1
1 0 0 bf800000 c0000000 c0000000 00 1
1 1 0 bf800000 3f800000 3f800000 00 1
1 0 0 00000000 80000000 80000000 00 1
1 0 0 7fc00000 40400000 40400000 00 1
1 1 0 c0000000 7fc00001 c0000000 00 1
1 0 0 7fc00000 ffc12345 7fc00000 00 1
1 1 0 7f800001 3f800000 3f800000 10 1
1 0 0 7fa00000 7fc00000 7fc00000 10 1
2 0 0 3f800000 40000000 00000001 00 0
2 0 1 3f800000 40000000 00000000 00 0
2 1 0 c0000000 bf800000 00000001 00 0
2 2 0 00000000 80000000 00000001 00 0
2 0 0 80000000 00000000 00000001 00 0
2 2 0 7fc00000 3f800000 00000000 00 0
2 2 1 7fc00000 3f800000 00000001 00 0
2 1 0 3f800000 ffc00000 00000000 10 0
2 2 0 7f800001 7f800001 00000000 10 0
2 1 1 ff800000 7f800000 00000000 00 0

// ==== compile.f ====
rtl/fpnc_pkg.sv
rtl/fp_classifier.sv
rtl/fpnc_pipe.sv
rtl/fp_noncomp.sv
rtl/fpnc_top.sv
bench/fpnc_checker.sv
bench/fpnc_sva.sv
bench/tb_fpnc_top.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module tb_fpnc_top -f compile.f -Mdir obj_dir -o sim_fpnc

run: compile
	@out="$$(./obj_dir/sim_fpnc +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
